/* logic/analog_ctrl_params.svh */
/*
 * Widths, setting offsets, PMA register addresses and field positions
 * for the analog settings controller. Include where a macro is needed.
 */
`ifndef ANALOG_CTRL_PARAMS_SVH
`define ANALOG_CTRL_PARAMS_SVH

// bus widths
`define ANALOG_DATA_W       32
`define ANALOG_OFFSET_W     6
`define ANALOG_ADDR_W       11
`define ANALOG_MODE_W       3

// user modes, anything but write reads
`define ANALOG_MODE_RD      3'd0
`define ANALOG_MODE_WR      3'd1

// user setting offsets
`define ANALOG_OFS_VOD      6'h00
`define ANALOG_OFS_POSTTAP1 6'h02
`define ANALOG_OFS_DCGAIN   6'h11
`define ANALOG_OFS_EQCTRL   6'h13

// PMA channel register addresses
`define ANALOG_REG_VOD      11'h005
`define ANALOG_REG_POSTTAP1 11'h003
`define ANALOG_REG_EQ       11'h018
`define ANALOG_REG_DCGAIN   11'h019

// field positions, lsb and length
`define ANALOG_VOD_LSB      5'd0
`define ANALOG_VOD_LEN      5'd6
`define ANALOG_POSTTAP1_LSB 5'd3
`define ANALOG_POSTTAP1_LEN 5'd5
`define ANALOG_DCGAIN_LSB   5'd0
`define ANALOG_DCGAIN_LEN   5'd4
`define ANALOG_EQ_LSB       5'd1
`define ANALOG_EQ_LEN       5'd15

`endif

/* logic/analog_ctrl_pkg.sv */
/*
 * Shared types of the analog settings controller: field descriptors,
 * user request, backend command and the equalizer stage word.
 */
`default_nettype none

`include "analog_ctrl_params.svh"

package analog_ctrl_pkg;

   // how a field value is coded in the register
   typedef enum logic [1:0]
   {
      raw         = 2'd0,  // plain bits
      thermometer = 2'd1,  // rx dc gain
      eq_table    = 2'd2   // rx equalizer level table
   } field_kind_e;

   // where a setting lives in the PMA channel
   typedef struct packed
   {
      logic [`ANALOG_ADDR_W-1:0] reg_addr;
      logic [4:0]                bit_lsb;
      logic [4:0]                bit_len;
      field_kind_e               kind;
   } field_desc_t;

   typedef struct packed
   {
      logic [`ANALOG_OFFSET_W-1:0] offset;
      logic [`ANALOG_MODE_W-1:0]   mode;
      logic [`ANALOG_DATA_W-1:0]   writedata;
   } user_req_t;

   typedef struct packed
   {
      logic                      opcode;     // 1 write, 0 read
      logic [`ANALOG_ADDR_W-1:0] addr;
      logic [`ANALOG_DATA_W-1:0] writedata;
   } ctrl_cmd_t;

   // equalizer stage controls, eqa in the low bits
   typedef struct packed
   {
      logic [2:0] eqv;
      logic [2:0] eqd;
      logic [2:0] eqc;
      logic [2:0] eqb;
      logic [2:0] eqa;
   } eq_stages_t;

   // register bits vs. stage view of the same word
   typedef union packed
   {
      logic [`ANALOG_EQ_LEN-1:0] word;
      eq_stages_t                stages;
   } eq_field_u;

endpackage

`default_nettype wire

/* logic/analog_field_map.sv */
/*
 * Maps a user setting offset onto its PMA register, bit position and
 * value coding. Unmapped offsets flag illegal with a zero descriptor.
 */
`timescale 1ns/10ps
`default_nettype none

`include "analog_ctrl_params.svh"

module analog_field_map
(
   input  logic [`ANALOG_OFFSET_W-1:0] offset,
   output analog_ctrl_pkg::field_desc_t field,
   output logic                        illegal
);

   always_comb
   begin
      field   = '0;
      illegal = 1'b0;
      case (offset)
         `ANALOG_OFS_VOD:
         begin
            field.reg_addr = `ANALOG_REG_VOD;       // tx output swing
            field.bit_lsb  = `ANALOG_VOD_LSB;
            field.bit_len  = `ANALOG_VOD_LEN;
            field.kind     = analog_ctrl_pkg::raw;
         end
         `ANALOG_OFS_POSTTAP1:
         begin
            field.reg_addr = `ANALOG_REG_POSTTAP1;  // shares reg with other taps
            field.bit_lsb  = `ANALOG_POSTTAP1_LSB;
            field.bit_len  = `ANALOG_POSTTAP1_LEN;
            field.kind     = analog_ctrl_pkg::raw;
         end
         `ANALOG_OFS_DCGAIN:
         begin
            field.reg_addr = `ANALOG_REG_DCGAIN;
            field.bit_lsb  = `ANALOG_DCGAIN_LSB;
            field.bit_len  = `ANALOG_DCGAIN_LEN;
            field.kind     = analog_ctrl_pkg::thermometer;
         end
         `ANALOG_OFS_EQCTRL:
         begin
            // five 3-bit stages above bit 0
            field.reg_addr = `ANALOG_REG_EQ;
            field.bit_lsb  = `ANALOG_EQ_LSB;
            field.bit_len  = `ANALOG_EQ_LEN;
            field.kind     = analog_ctrl_pkg::eq_table;
         end
         default:
         begin
            illegal = 1'b1;  // not a kept setting
         end
      endcase
   end

endmodule

`default_nettype wire

/* logic/analog_value_codec.sv */
/*
 * Converts between user values and LSB-aligned register field bits.
 * Raw fields are masked, dc gain uses a thermometer code and the
 * equalizer level goes through the 15-entry stage table.
 */
`timescale 1ns/10ps
`default_nettype none

`include "analog_ctrl_params.svh"

module analog_value_codec
(
   input  analog_ctrl_pkg::field_kind_e kind,
   input  logic [4:0]                   bit_len,
   input  logic [`ANALOG_DATA_W-1:0]    user_value,
   input  logic [`ANALOG_DATA_W-1:0]    field_in,    // register bits, lsb aligned
   output logic [`ANALOG_DATA_W-1:0]    field_out,   // encoded, lsb aligned
   output logic [`ANALOG_DATA_W-1:0]    user_out
);

   ////////////////////////////////////////
   // equalizer stage table
   ////////////////////////////////////////

   // {eqv, eqd, eqc, eqb, eqa} per level, level 0 all off
   function automatic analog_ctrl_pkg::eq_stages_t eq_level(input logic [3:0] level);
      case (level)
         4'd1:    return {3'd0, 3'd0, 3'd0, 3'd0, 3'd3};  // low gain
         4'd2:    return {3'd0, 3'd0, 3'd0, 3'd0, 3'd4};
         4'd3:    return {3'd4, 3'd0, 3'd0, 3'd0, 3'd7};
         4'd4:    return {3'd7, 3'd0, 3'd0, 3'd0, 3'd7};
         4'd5:    return {3'd0, 3'd0, 3'd0, 3'd7, 3'd7};
         4'd6:    return {3'd4, 3'd0, 3'd0, 3'd7, 3'd7};  // medium gain
         4'd7:    return {3'd0, 3'd0, 3'd3, 3'd7, 3'd7};
         4'd8:    return {3'd0, 3'd0, 3'd7, 3'd7, 3'd7};
         4'd9:    return {3'd2, 3'd0, 3'd7, 3'd7, 3'd7};
         4'd10:   return {3'd4, 3'd0, 3'd7, 3'd7, 3'd7};
         4'd11:   return {3'd0, 3'd7, 3'd7, 3'd7, 3'd7};  // high gain
         4'd12:   return {3'd2, 3'd7, 3'd7, 3'd7, 3'd7};
         4'd13:   return {3'd4, 3'd7, 3'd7, 3'd7, 3'd7};
         4'd14:   return {3'd6, 3'd7, 3'd7, 3'd7, 3'd7};
         4'd15:   return {3'd7, 3'd7, 3'd7, 3'd7, 3'd7};
         default: return '0;
      endcase
   endfunction

   logic [`ANALOG_DATA_W-1:0] len_mask;
   logic [3:0]                therm_enc;
   logic [2:0]                therm_dec;
   logic [3:0]                eq_dec;
   analog_ctrl_pkg::eq_field_u eq_in;
   analog_ctrl_pkg::eq_field_u eq_out;

   assign len_mask = (32'd1 << bit_len) - 32'd1;

   // dc gain thermometer, fills from the msb
   always_comb
   begin
      case (user_value[2:0])
         3'd0:    therm_enc = 4'b0000;
         3'd1:    therm_enc = 4'b1000;
         3'd2:    therm_enc = 4'b1100;
         3'd3:    therm_enc = 4'b1110;
         default: therm_enc = 4'b1111;  // 4 and above saturate
      endcase
      case (field_in[3:0])
         4'b1000: therm_dec = 3'd1;
         4'b1100: therm_dec = 3'd2;
         4'b1110: therm_dec = 3'd3;
         4'b1111: therm_dec = 3'd4;
         default: therm_dec = 3'd0;     // 0000 or not a thermometer code
      endcase
   end

   // equalizer, encode by lookup and decode by search
   always_comb
   begin
      eq_out.stages = eq_level(user_value[3:0]);
      eq_in.word    = field_in[`ANALOG_EQ_LEN-1:0];
      eq_dec        = 4'd0;  // no match reads as level 0
      for (int lvl = 1; lvl < 16; lvl++)
      begin
         if (eq_in.stages == eq_level(4'(lvl)))
            eq_dec = 4'(lvl);
      end
   end

   always_comb
   begin
      field_out = '0;
      user_out  = '0;
      case (kind)
         analog_ctrl_pkg::raw:
         begin
            field_out = user_value & len_mask;
            user_out  = field_in & len_mask;
         end
         analog_ctrl_pkg::thermometer:
         begin
            field_out[3:0] = therm_enc;
            user_out[2:0]  = therm_dec;
         end
         analog_ctrl_pkg::eq_table:
         begin
            field_out[`ANALOG_EQ_LEN-1:0] = eq_out.word;
            user_out[3:0]                 = eq_dec;
         end
         default:
         begin
            field_out = '0;
            user_out  = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* logic/analog_rmw_sequencer.sv */
/*
 * Request latch and read-modify-write FSM towards the PMA backend.
 * A read is one backend read. A write is a locked read then write with
 * the new field merged in. Owns busy, lock and the offset error.
 */
`timescale 1ns/10ps
`default_nettype none

`include "analog_ctrl_params.svh"

module analog_rmw_sequencer
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         go,
   input  analog_ctrl_pkg::user_req_t   req,
   input  analog_ctrl_pkg::field_desc_t field,
   input  logic                         illegal,
   input  logic [`ANALOG_DATA_W-1:0]    enc_field,
   input  logic [`ANALOG_DATA_W-1:0]    dec_value,
   output analog_ctrl_pkg::user_req_t   req_q,
   output logic [`ANALOG_DATA_W-1:0]    rd_field,
   output logic                         busy,
   output logic                         illegal_offset_error,
   output logic [`ANALOG_DATA_W-1:0]    readdata,
   output logic                         ctrl_go,
   output analog_ctrl_pkg::ctrl_cmd_t   ctrl_cmd,
   output logic                         ctrl_lock,
   input  logic                         ctrl_wait,
   input  logic [`ANALOG_DATA_W-1:0]    ctrl_readdata
);

   typedef enum logic [1:0]
   {
      st_idle,
      st_read,
      st_write,
      st_finish
   } seq_state_e;

   seq_state_e                 state;
   analog_ctrl_pkg::user_req_t req_hold;
   logic [`ANALOG_DATA_W-1:0]  rd_word;     // word from the backend read
   logic [`ANALOG_DATA_W-1:0]  fld_mask;
   logic [`ANALOG_DATA_W-1:0]  merged;
   logic                       accept;
   logic                       is_write;
   logic                       access_done;

   assign busy   = (state != st_idle);
   assign accept = go & ~busy;   // go during busy is dropped

   // live request in the go cycle so illegal is known at that edge
   assign req_q    = accept ? req : req_hold;
   assign is_write = (req_q.mode == `ANALOG_MODE_WR);

   // wait is never up in the ctrl_go cycle, so skip that one
   assign access_done = ~ctrl_go & ~ctrl_wait;

   ////////////////////////////////////////
   // field extract and merge
   ////////////////////////////////////////

   assign rd_field = rd_word >> field.bit_lsb;
   assign fld_mask = ((32'd1 << field.bit_len) - 32'd1) << field.bit_lsb;
   assign merged   = (rd_word & ~fld_mask) | ((enc_field << field.bit_lsb) & fld_mask);

   assign ctrl_cmd = '{opcode:    (state == st_write),
                       addr:      field.reg_addr,
                       writedata: merged};

   // payload, no reset
   always_ff @(posedge clk)
   begin
      if (accept)
         req_hold <= req;
      if (state == st_read && access_done)
         rd_word <= ctrl_readdata;  // only valid in the done cycle
   end

   ////////////////////////////////////////
   // control FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state                <= st_idle;
         ctrl_go              <= 1'b0;
         ctrl_lock            <= 1'b0;
         illegal_offset_error <= 1'b0;
         readdata             <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (accept)
               begin
                  if (illegal)
                     illegal_offset_error <= 1'b1;   // no backend access
                  else
                  begin
                     illegal_offset_error <= 1'b0;
                     ctrl_go              <= 1'b1;   // read always goes first
                     ctrl_lock            <= 1'b1;
                     state                <= st_read;
                  end
               end
            end
            st_read:
            begin
               ctrl_go <= 1'b0;
               if (access_done)
               begin
                  if (is_write)
                  begin
                     ctrl_go <= 1'b1;  // write back, lock held
                     state   <= st_write;
                  end
                  else
                  begin
                     ctrl_lock <= 1'b0;
                     state     <= st_finish;
                  end
               end
            end
            st_write:
            begin
               ctrl_go <= 1'b0;
               if (access_done)
               begin
                  ctrl_lock <= 1'b0;
                  state     <= st_finish;
               end
            end
            st_finish:
            begin
               if (!is_write)
                  readdata <= dec_value;  // writes leave readdata alone
               state <= st_idle;
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* logic/analog_ctrl_top.sv */
/*
 * Top of the transceiver analog settings controller. The user side
 * issues go with a request, the backend side carries locked PMA accesses.
 */
`timescale 1ns/10ps
`default_nettype none

`include "analog_ctrl_params.svh"

module analog_ctrl_top
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       go,
   input  analog_ctrl_pkg::user_req_t req,
   output logic                       busy,
   output logic                       illegal_offset_error,
   output logic [`ANALOG_DATA_W-1:0]  readdata,
   output logic                       ctrl_go,
   output analog_ctrl_pkg::ctrl_cmd_t ctrl_cmd,
   output logic                       ctrl_lock,
   input  logic                       ctrl_wait,
   input  logic [`ANALOG_DATA_W-1:0]  ctrl_readdata
);

   analog_ctrl_pkg::user_req_t   req_q;      // latched request
   analog_ctrl_pkg::field_desc_t field;
   logic                         illegal;
   logic [`ANALOG_DATA_W-1:0]    enc_field;  // new field bits
   logic [`ANALOG_DATA_W-1:0]    dec_value;  // user value of read field
   logic [`ANALOG_DATA_W-1:0]    rd_field;

   analog_field_map u_field_map
   (
      .offset  (req_q.offset),
      .field   (field),
      .illegal (illegal)
   );

   analog_value_codec u_value_codec
   (
      .kind       (field.kind),
      .bit_len    (field.bit_len),
      .user_value (req_q.writedata),
      .field_in   (rd_field),
      .field_out  (enc_field),
      .user_out   (dec_value)
   );

   analog_rmw_sequencer u_rmw_sequencer
   (
      .clk                  (clk),
      .reset                (reset),
      .go                   (go),
      .req                  (req),
      .field                (field),
      .illegal              (illegal),
      .enc_field            (enc_field),
      .dec_value            (dec_value),
      .req_q                (req_q),
      .rd_field             (rd_field),
      .busy                 (busy),
      .illegal_offset_error (illegal_offset_error),
      .readdata             (readdata),
      .ctrl_go              (ctrl_go),
      .ctrl_cmd             (ctrl_cmd),
      .ctrl_lock            (ctrl_lock),
      .ctrl_wait            (ctrl_wait),
      .ctrl_readdata        (ctrl_readdata)
   );

endmodule

`default_nettype wire

/* dv/analog_ctrl_tb.sv */
/*
 * Testbench for the analog settings controller. Directed and LFSR-driven
 * requests run against a backend register model and a reference model.
 */
`timescale 1ns/10ps
`default_nettype none

`include "analog_ctrl_params.svh"

module analog_ctrl_tb;

   localparam int num_reqs   = 200;
   localparam int max_cycles = num_reqs * 20;  // a write with 4 wait cycles takes about 15

   logic                       clk;
   logic                       reset;
   logic                       go;
   analog_ctrl_pkg::user_req_t req;
   logic                       busy;
   logic                       illegal_offset_error;
   logic [31:0]                readdata;
   logic                       ctrl_go;
   analog_ctrl_pkg::ctrl_cmd_t ctrl_cmd;
   logic                       ctrl_lock;
   logic                       ctrl_wait     = 1'b0;
   logic [31:0]                ctrl_readdata = '0;

   logic [31:0] lfsr = 32'd62;
   logic [31:0] be_regs  [4];  // backend registers: vod, posttap1, eq, dcgain
   logic [31:0] exp_regs [4];  // reference copy
   logic [31:0] exp_readdata;
   int          errors      = 0;
   int          reqs_done   = 0;
   int          cycle_count = 0;
   int          rd_count    = 0;
   int          wr_count    = 0;

   // backend access in flight
   logic        preloaded    = 1'b0;
   logic        wait_active  = 1'b0;
   logic        in_access    = 1'b0;
   logic        done_pending = 1'b0;  // completion edge comes next
   logic        acc_write;
   int          acc_idx;
   int          wait_cnt;
   logic [31:0] acc_data;

   analog_ctrl_top u_dut
   (
      .clk                  (clk),
      .reset                (reset),
      .go                   (go),
      .req                  (req),
      .busy                 (busy),
      .illegal_offset_error (illegal_offset_error),
      .readdata             (readdata),
      .ctrl_go              (ctrl_go),
      .ctrl_cmd             (ctrl_cmd),
      .ctrl_lock            (ctrl_lock),
      .ctrl_wait            (ctrl_wait),
      .ctrl_readdata        (ctrl_readdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= max_cycles)
      begin
         $display("timeout: run passed %0d cycles before all requests finished", max_cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // stimulus source and reference model
   ////////////////////////////////////////

   // galois lfsr, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [14:0] eq_pack(input int a, input int b, input int c,
                                           input int d, input int v);
      return {3'(v), 3'(d), 3'(c), 3'(b), 3'(a)};  // eqa sits lowest
   endfunction

   // level table, args in eqa..eqv order
   function automatic logic [14:0] eq_stages(input logic [3:0] level);
      case (level)
         4'd1:    return eq_pack(3, 0, 0, 0, 0);
         4'd2:    return eq_pack(4, 0, 0, 0, 0);
         4'd3:    return eq_pack(7, 0, 0, 0, 4);
         4'd4:    return eq_pack(7, 0, 0, 0, 7);
         4'd5:    return eq_pack(7, 7, 0, 0, 0);
         4'd6:    return eq_pack(7, 7, 0, 0, 4);
         4'd7:    return eq_pack(7, 7, 3, 0, 0);
         4'd8:    return eq_pack(7, 7, 7, 0, 0);
         4'd9:    return eq_pack(7, 7, 7, 0, 2);
         4'd10:   return eq_pack(7, 7, 7, 0, 4);
         4'd11:   return eq_pack(7, 7, 7, 7, 0);
         4'd12:   return eq_pack(7, 7, 7, 7, 2);
         4'd13:   return eq_pack(7, 7, 7, 7, 4);
         4'd14:   return eq_pack(7, 7, 7, 7, 6);
         4'd15:   return eq_pack(7, 7, 7, 7, 7);
         default: return '0;
      endcase
   endfunction

   // n ones from the top, 5 to 7 saturate
   function automatic logic [3:0] therm_code(input logic [2:0] n);
      logic [2:0] c;
      c = (n > 3'd4) ? 3'd4 : n;
      return 4'b1111 << (3'd4 - c);
   endfunction

   function automatic logic [31:0] encode(input logic [1:0] kind, input logic [4:0] len,
                                          input logic [31:0] v);
      case (kind)
         2'd0:    return v & ((32'd1 << len) - 32'd1);
         2'd1:    return {28'd0, therm_code(v[2:0])};
         default: return {17'd0, eq_stages(v[3:0])};
      endcase
   endfunction

   function automatic logic [31:0] decode(input logic [1:0] kind, input logic [4:0] len,
                                          input logic [31:0] bits);
      case (kind)
         2'd0:    return bits & ((32'd1 << len) - 32'd1);
         2'd1:
         begin
            for (int n = 0; n < 5; n++)
               if (bits[3:0] == therm_code(3'(n)))
                  return 32'(n);
            return '0;  // not a thermometer code
         end
         default:
         begin
            for (int lvl = 1; lvl < 16; lvl++)
               if (bits[14:0] == eq_stages(4'(lvl)))
                  return 32'(lvl);
            return '0;
         end
      endcase
   endfunction

   function automatic int addr_index(input logic [10:0] addr);
      case (addr)
         `ANALOG_REG_VOD:      return 0;
         `ANALOG_REG_POSTTAP1: return 1;
         `ANALOG_REG_EQ:       return 2;
         `ANALOG_REG_DCGAIN:   return 3;
         default:              return -1;
      endcase
   endfunction

   function automatic logic [5:0] ofs_of(input logic [1:0] idx);
      case (idx)
         2'd0:    return `ANALOG_OFS_VOD;
         2'd1:    return `ANALOG_OFS_POSTTAP1;
         2'd2:    return `ANALOG_OFS_EQCTRL;
         default: return `ANALOG_OFS_DCGAIN;
      endcase
   endfunction

   // kind 0 raw, 1 thermometer, 2 eq table
   task automatic field_lookup(input logic [5:0] ofs, output logic legal,
                               output logic [1:0] idx, output logic [4:0] lsb,
                               output logic [4:0] len, output logic [1:0] kind);
      legal = 1'b1;
      case (ofs)
         `ANALOG_OFS_VOD:
            {idx, lsb, len, kind} = {2'd0, `ANALOG_VOD_LSB, `ANALOG_VOD_LEN, 2'd0};
         `ANALOG_OFS_POSTTAP1:
            {idx, lsb, len, kind} = {2'd1, `ANALOG_POSTTAP1_LSB, `ANALOG_POSTTAP1_LEN, 2'd0};
         `ANALOG_OFS_EQCTRL:
            {idx, lsb, len, kind} = {2'd2, `ANALOG_EQ_LSB, `ANALOG_EQ_LEN, 2'd2};
         `ANALOG_OFS_DCGAIN:
            {idx, lsb, len, kind} = {2'd3, `ANALOG_DCGAIN_LSB, `ANALOG_DCGAIN_LEN, 2'd1};
         default:
         begin
            legal                 = 1'b0;
            {idx, lsb, len, kind} = '0;
         end
      endcase
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         report_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
         report_error($sformatf("%s got %b expected %b", what, got, exp));
   endtask

   ////////////////////////////////////////
   // requests
   ////////////////////////////////////////

   task automatic do_request(input logic [5:0] ofs, input logic [2:0] mode,
                             input logic [31:0] wdata, input logic extra_go);
      logic        legal;
      logic        is_wr;
      logic [1:0]  idx;
      logic [1:0]  kind;
      logic [4:0]  lsb;
      logic [4:0]  len;
      logic [31:0] enc;
      int          rd0;
      int          wr0;
      field_lookup(ofs, legal, idx, lsb, len, kind);
      is_wr = legal && (mode == `ANALOG_MODE_WR);
      rd0   = rd_count;
      wr0   = wr_count;
      @(negedge clk);
      req = '{offset: ofs, mode: mode, writedata: wdata};
      go  = 1'b1;
      @(negedge clk);
      go = legal & extra_go;  // lands while busy, must be dropped
      check_flag("busy after go", busy, legal);
      check_flag("ctrl_go after go", ctrl_go, legal);
      check_flag("illegal_offset_error after go", illegal_offset_error, ~legal);
      @(negedge clk);
      go = 1'b0;
      while (busy)
         @(negedge clk);
      if (is_wr)
      begin
         enc = encode(kind, len, wdata);
         for (int i = 0; i < 32; i++)
            if (i < len)
               exp_regs[idx][lsb + i] = enc[i];  // field bits only
      end
      else if (legal)
         exp_readdata = decode(kind, len, exp_regs[idx] >> lsb);
      check_word("backend reads", 32'(rd_count - rd0), {31'd0, legal});
      check_word("backend writes", 32'(wr_count - wr0), {31'd0, is_wr});
      check_word("readdata", readdata, exp_readdata);
      for (int i = 0; i < 4; i++)
         check_word($sformatf("register %0d", i), be_regs[i], exp_regs[i]);
      check_flag("ctrl_lock after request", ctrl_lock, 1'b0);
      reqs_done++;
   endtask

   task automatic random_request();
      logic [5:0]  ofs;
      logic [2:0]  mode;
      logic [31:0] wdata;
      logic        extra;
      ofs = ofs_of(2'(rand_bits(2)));
      if (rand_bits(3) == 32'd0)
         ofs = 6'(rand_bits(6)) | 6'h20;  // nothing mapped up there
      mode = 3'(rand_bits(3));
      if (rand_bits(1) != 32'd0)
         mode = `ANALOG_MODE_WR;
      else if (mode == `ANALOG_MODE_WR)
         mode = `ANALOG_MODE_RD;
      wdata = rand_bits(32);
      extra = 1'(rand_bits(1));
      do_request(ofs, mode, wdata, extra);
   endtask

   ////////////////////////////////////////
   // backend model
   ////////////////////////////////////////

   always @(negedge clk)
   begin
      if (!preloaded)
      begin
         for (int i = 0; i < 4; i++)
            be_regs[i] = rand_bits(32);
         be_regs[3][3:0] = 4'b0101;  // dc gain outside the thermometer codes
         be_regs[2][3:1] = 3'd5;     // eqa of 5 is in no level
         preloaded       = 1'b1;
      end
      if (done_pending)
      begin
         done_pending = 1'b0;
         in_access    = 1'b0;
      end
      if (in_access && !ctrl_lock)
         report_error("ctrl_lock low during a backend access");
      if (ctrl_go)
      begin
         if (wait_active || in_access)
            report_error("ctrl_go while an access is in flight");
         if (!ctrl_lock)
            report_error("ctrl_lock low at ctrl_go");
         acc_idx   = addr_index(ctrl_cmd.addr);
         acc_write = ctrl_cmd.opcode;
         acc_data  = ctrl_cmd.writedata;
         if (acc_idx < 0)
            report_error("backend access to an unmapped address");
         if (acc_write)
            wr_count++;
         else
            rd_count++;
         in_access   = 1'b1;
         wait_active = 1'b1;
         wait_cnt    = 1 + int'(rand_bits(2));  // 1 to 4 cycles of wait
      end
      else if (wait_active)
      begin
         if (wait_cnt == 0)
         begin
            ctrl_wait    = 1'b0;
            wait_active  = 1'b0;
            done_pending = 1'b1;
            if (acc_idx >= 0 && acc_write)
               be_regs[acc_idx] = acc_data;
            else if (acc_idx >= 0)
               ctrl_readdata = be_regs[acc_idx];  // valid in the done cycle
         end
         else
         begin
            ctrl_wait = 1'b1;  // up from the cycle after ctrl_go
            wait_cnt--;
         end
      end
   end

   initial
   begin
      reset        = 1'b1;
      go           = 1'b0;
      req          = '0;
      exp_readdata = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_flag("busy after reset", busy, 1'b0);
      check_flag("ctrl_go after reset", ctrl_go, 1'b0);
      check_flag("ctrl_lock after reset", ctrl_lock, 1'b0);
      check_flag("illegal_offset_error after reset", illegal_offset_error, 1'b0);
      check_word("readdata after reset", readdata, 32'd0);
      for (int i = 0; i < 4; i++)
         exp_regs[i] = be_regs[i];
      for (int i = 0; i < 4; i++)  // preloaded patterns first
         do_request(ofs_of(2'(i)), `ANALOG_MODE_RD, 32'd0, 1'b0);
      for (int lvl = 0; lvl < 16; lvl++)
      begin
         do_request(`ANALOG_OFS_EQCTRL, `ANALOG_MODE_WR, 32'(lvl), 1'b0);
         do_request(`ANALOG_OFS_EQCTRL, `ANALOG_MODE_RD, 32'd0, 1'b1);
      end
      for (int n = 0; n < 8; n++)
      begin
         do_request(`ANALOG_OFS_DCGAIN, `ANALOG_MODE_WR, 32'(n), 1'b1);
         do_request(`ANALOG_OFS_DCGAIN, `ANALOG_MODE_RD, 32'd0, 1'b0);
      end
      do_request(6'h3f, `ANALOG_MODE_RD, 32'd0, 1'b0);
      while (reqs_done < num_reqs)
         random_request();
      $display("requests %0d, backend reads %0d, backend writes %0d, errors %0d",
               reqs_done, rd_count, wr_count, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

/* analog_ctrl_top.f */
+incdir+logic
logic/analog_ctrl_pkg.sv
logic/analog_field_map.sv
logic/analog_value_codec.sv
logic/analog_rmw_sequencer.sv
logic/analog_ctrl_top.sv
dv/analog_ctrl_tb.sv

/* Makefile */
# Verilator flow for the analog settings controller

TB_TOP = analog_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f analog_ctrl_top.f --top-module analog_ctrl_top

sim:
	verilator --binary --timing -f analog_ctrl_top.f --top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
